// ==== files.f ====
hw/rv32i_types.sv
hw/tomasulo_types.sv
hw/tomasulo_ifs.sv
hw/reservation_station.sv
hw/alu_unit.sv
hw/reorder_buffer.sv
hw/dispatch_unit.sv
hw/tomasulo_core.sv
verification/tb_tomasulo_core.sv

// ==== Bender.yml ====
package:
  name: tomasulo_core

sources:
  # packages first, then interfaces and modules
  - hw/rv32i_types.sv
  - hw/tomasulo_types.sv
  - hw/tomasulo_ifs.sv
  - hw/reservation_station.sv
  - hw/alu_unit.sv
  - hw/reorder_buffer.sv
  - hw/dispatch_unit.sv
  - hw/tomasulo_core.sv
  - target: test
    files:
      - verification/tb_tomasulo_core.sv

// ==== verification/tb_tomasulo_core.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_tomasulo_core;

    // cycles a single instruction may wait for instr_ready
    localparam int ACCEPT_LIMIT = 200;
    // cycles allowed for all outstanding work to commit
    localparam int DRAIN_LIMIT  = 500;

    logic        clk = 1'b0;
    logic        rst;
    logic        instr_valid;
    logic [31:0] instr;
    logic        instr_ready;
    logic        commit_valid;
    logic [4:0]  commit_rd;
    logic [31:0] commit_data;

    // reference register file, x0 never written
    logic [31:0] mregs [32];
    // expected commits as {rd, value}, oldest first
    logic [36:0] exp_q [$];
    logic [15:0] lfsr = 16'd90;
    string       test_name;
    int          accepted;
    int          commits;

    tomasulo_core #(
        .NUM_STATIONS(3)
    ) dut (
        .clk          (clk),
        .rst          (rst),
        .instr_valid  (instr_valid),
        .instr        (instr),
        .instr_ready  (instr_ready),
        .commit_valid (commit_valid),
        .commit_rd    (commit_rd),
        .commit_data  (commit_data)
    );

    always #5 clk = ~clk;

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // one lfsr step per bit, newest bit lands in the lsb
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr = lfsr_step(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    task automatic abort_run();
        $display("Simulation FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("CHECK FAILED: %s %s expected 0x%08h actual 0x%08h",
                     test_name, what, expected, actual);
            abort_run();
        end
    endtask

    // registers limited to x0..x7 so dependencies show up often
    function automatic logic [31:0] random_instr(input logic force_imm, input logic x0_src);
        rv32i_types::instr_u u;
        logic [2:0]          f3;
        logic                alt;
        logic                pick_imm;
        logic [11:0]         imm12;
        f3       = 3'(rand_bits(3));
        alt      = 1'(rand_bits(1));
        pick_imm = 1'(rand_bits(1)) | force_imm;
        imm12    = 12'(rand_bits(12));
        u        = '0;
        if (pick_imm) begin
            // shift immediates keep funct7 in the top bits
            if (f3 == 3'b001 || f3 == 3'b101) begin
                imm12[11:5] = {1'b0, alt && (f3 == 3'b101), 5'd0};
            end
            u.i.opcode = rv32i_types::OP_IMM;
            u.i.imm    = imm12;
        end else begin
            u.r.opcode = rv32i_types::OP;
            u.r.rs2    = 5'(rand_bits(3));
            // funct7 0x20 only legal for sub and sra
            u.r.funct7 = (alt && (f3 == 3'b000 || f3 == 3'b101)) ? 7'h20 : 7'h00;
        end
        u.r.funct3 = f3;
        u.r.rd     = 5'(rand_bits(3));
        u.r.rs1    = x0_src ? 5'd0 : 5'(rand_bits(3));
        return u;
    endfunction

    // sequential execution of one accepted instruction
    task automatic model_accept(input logic [31:0] word);
        rv32i_types::instr_u u;
        logic [31:0]         a;
        logic [31:0]         b;
        logic [31:0]         y;
        u = word;
        a = mregs[u.r.rs1];
        if (u.r.opcode == rv32i_types::OP_IMM) begin
            b = {{20{u.i.imm[11]}}, u.i.imm};
        end else begin
            b = mregs[u.r.rs2];
        end
        case (u.r.funct3)
            3'b000: y = (u.r.opcode == rv32i_types::OP && u.r.funct7[5]) ? a - b : a + b;
            3'b001: y = a << b[4:0];
            3'b010: y = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011: y = (a < b) ? 32'd1 : 32'd0;
            3'b100: y = a ^ b;
            3'b101: begin
                // arithmetic shift kept apart from the logical one
                if (u.r.funct7[5]) begin
                    y = $signed(a) >>> b[4:0];
                end else begin
                    y = a >> b[4:0];
                end
            end
            3'b110: y = a | b;
            default: y = a & b;
        endcase
        if (u.r.rd != 5'd0) begin
            mregs[u.r.rd] = y;
        end
        // x0 writes still commit the computed value
        exp_q.push_back({u.r.rd, y});
        accepted++;
    endtask

    // score any commit on one rising edge and report whether the instruction went in
    task automatic wait_edge(output logic took);
        logic [36:0] e;
        @(posedge clk);
        took = instr_valid && instr_ready;
        // eight in flight means the rob is full
        // an entry is freed one cycle before its commit shows up
        if (accepted - commits - int'(commit_valid) >= tomasulo_types::ROB_DEPTH) begin
            check_value("ready low with rob full", 32'd0, 32'(instr_ready));
        end
        if (commit_valid) begin
            if (exp_q.size() == 0) begin
                $display("commit to x%0d with no instruction outstanding", commit_rd);
                abort_run();
            end
            e = exp_q.pop_front();
            check_value("commit rd", 32'(e[36:32]), 32'(commit_rd));
            check_value("commit data", e[31:0], commit_data);
            commits++;
        end
    endtask

    // present one instruction and hold it until accepted
    task automatic issue(input logic [31:0] word);
        logic took;
        int   waited;
        instr_valid <= 1'b1;
        instr       <= word;
        took   = 1'b0;
        waited = 0;
        while (!took) begin
            if (waited == ACCEPT_LIMIT) begin
                $display("instruction %08h never accepted, instr_ready stayed low", word);
                abort_run();
            end
            wait_edge(took);
            waited++;
        end
        model_accept(word);
    endtask

    task automatic idle(input int n);
        logic took;
        instr_valid <= 1'b0;
        repeat (n) wait_edge(took);
    endtask

    // stop issuing and wait for every expected commit
    task automatic drain();
        logic took;
        int   waited;
        instr_valid <= 1'b0;
        waited = 0;
        while (exp_q.size() != 0) begin
            if (waited == DRAIN_LIMIT) begin
                $display("core stopped committing with %0d instructions outstanding",
                         exp_q.size());
                abort_run();
            end
            wait_edge(took);
            waited++;
        end
        // stray or duplicated commits would show up here
        repeat (tomasulo_types::ROB_DEPTH) wait_edge(took);
        // nothing in flight, so the core must take input again
        check_value("ready when idle", 32'd1, 32'(instr_ready));
    endtask

    initial begin
        rv32i_types::instr_u u;
        rst         <= 1'b1;
        instr_valid <= 1'b0;
        instr       <= '0;
        accepted = 0;
        commits  = 0;
        for (int r = 0; r < 32; r++) begin
            mregs[r] = '0;
        end
        repeat (2) @(posedge clk);
        rst <= 1'b0;

        // immediates off x0 only, no renaming hazards
        test_name = "independent";
        for (int n = 0; n < 24; n++) begin
            issue(random_instr(1'b1, 1'b1));
        end
        drain();

        // back to back through x1..x7
        test_name = "dependency";
        for (int n = 0; n < 200; n++) begin
            issue(random_instr(1'b0, 1'b0));
        end
        drain();

        test_name = "x0_writes";
        for (int n = 0; n < 16; n++) begin
            u      = random_instr(1'b0, 1'b0);
            u.r.rd = 5'd0;
            issue(u);
        end
        for (int n = 0; n < 16; n++) begin
            issue(random_instr(1'b0, 1'b1));
        end
        drain();

        // long bursts with valid held high
        test_name = "backpressure";
        for (int b = 0; b < 10; b++) begin
            for (int n = 0; n < 20; n++) begin
                issue(random_instr(1'b0, 1'b0));
            end
            idle(1 + int'(rand_bits(3)));
        end
        drain();

        test_name = "random";
        for (int n = 0; n < 2000; n++) begin
            issue(random_instr(1'b0, 1'b0));
            if (rand_bits(2) == 0) begin
                idle(1 + int'(rand_bits(2)));
            end
        end
        drain();

        $display("Simulation PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== hw/tomasulo_core.sv ====
`timescale 1ns/1ns
`default_nettype none

module tomasulo_core #(
    parameter int NUM_STATIONS = 3
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         instr_valid,
    input  logic [31:0]                  instr,
    output logic                         instr_ready,
    output logic                         commit_valid,
    output logic [4:0]                   commit_rd,
    output logic [rv32i_types::XLEN-1:0] commit_data
);

    // station to alu request lines
    logic [NUM_STATIONS-1:0]   start_exe;
    logic [NUM_STATIONS-1:0]   grant;
    tomasulo_types::alu_word_t alu_data [NUM_STATIONS];

    dispatch_if   disp_bus [NUM_STATIONS] ();
    result_bus_if res_bus ();
    commit_if     cmt_bus ();

    dispatch_unit #(
        .NUM_STATIONS(NUM_STATIONS)
    ) u_dispatch (
        .clk         (clk),
        .rst         (rst),
        .instr_valid (instr_valid),
        .instr       (instr),
        .instr_ready (instr_ready),
        .stations    (disp_bus),
        .results     (res_bus),
        .commit      (cmt_bus)
    );

    for (genvar i = 0; i < NUM_STATIONS; i++) begin : g_rs
        reservation_station u_rs (
            .clk       (clk),
            .rst       (rst),
            .disp      (disp_bus[i]),
            .results   (res_bus),
            .start_exe (start_exe[i]),
            .alu_data  (alu_data[i]),
            .grant     (grant[i])
        );
    end

    alu_unit #(
        .NUM_STATIONS(NUM_STATIONS)
    ) u_alu (
        .start_exe (start_exe),
        .alu_data  (alu_data),
        .grant     (grant),
        .wr        (res_bus)
    );

    reorder_buffer u_rob (
        .clk          (clk),
        .rst          (rst),
        .commit       (cmt_bus),
        .results      (res_bus),
        .commit_valid (commit_valid),
        .commit_rd    (commit_rd),
        .commit_data  (commit_data)
    );

endmodule

`default_nettype wire

// ==== hw/dispatch_unit.sv ====
`timescale 1ns/1ns
`default_nettype none

module dispatch_unit #(
    parameter int NUM_STATIONS = 3
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                instr_valid,
    input  rv32i_types::instr_u instr,
    output logic                instr_ready,
    dispatch_if.producer        stations [NUM_STATIONS],
    result_bus_if.reader        results,
    commit_if.dispatch          commit
);

    // architectural registers and rename table
    logic [rv32i_types::XLEN-1:0] regs [32];
    logic [31:0]                  reg_busy;
    tomasulo_types::tag_t         reg_tag [32];

    logic [NUM_STATIONS-1:0]   empty_vec;
    logic [NUM_STATIONS-1:0]   load_sel;
    logic                      accept;
    logic                      is_imm;
    rv32i_types::alu_op_e      op;
    tomasulo_types::res_word_t res_word;

    // regfile when the source is idle, else rob by tag
    function automatic tomasulo_types::src_t read_src(input logic [4:0] rs);
        tomasulo_types::src_t s;
        s.tag   = reg_tag[rs];
        s.data  = regs[rs];
        s.valid = 1'b1;
        if (reg_busy[rs]) begin
            // producer may already have finished
            s.valid = results.calculated[reg_tag[rs]];
            s.data  = results.result[reg_tag[rs]];
        end
        return s;
    endfunction

    assign is_imm = instr.r.opcode == rv32i_types::OP_IMM;

    // funct7 bit 30 picks sub and sra, sub only for register form
    always_comb begin
        case (instr.r.funct3)
            rv32i_types::F3_ADD:  op = (!is_imm && instr.r.funct7[5]) ?
                                       rv32i_types::ALU_SUB : rv32i_types::ALU_ADD;
            rv32i_types::F3_SLL:  op = rv32i_types::ALU_SLL;
            rv32i_types::F3_SLT:  op = rv32i_types::ALU_SLT;
            rv32i_types::F3_SLTU: op = rv32i_types::ALU_SLTU;
            rv32i_types::F3_XOR:  op = rv32i_types::ALU_XOR;
            rv32i_types::F3_SR:   op = instr.r.funct7[5] ?
                                       rv32i_types::ALU_SRA : rv32i_types::ALU_SRL;
            rv32i_types::F3_OR:   op = rv32i_types::ALU_OR;
            default:              op = rv32i_types::ALU_AND;
        endcase
    end

    always_comb begin
        res_word.op     = op;
        res_word.src1   = read_src(instr.r.rs1);
        res_word.src2   = read_src(instr.r.rs2);
        res_word.rd_tag = commit.tail_tag;
        // immediate replaces rs2, already valid
        if (is_imm) begin
            res_word.src2.tag   = '0;
            res_word.src2.data  = {{(rv32i_types::XLEN - 12){instr.i.imm[11]}}, instr.i.imm};
            res_word.src2.valid = 1'b1;
        end
    end

    // lowest numbered empty station wins
    always_comb begin
        load_sel = '0;
        for (int i = NUM_STATIONS - 1; i >= 0; i--) begin
            if (empty_vec[i]) begin
                load_sel = NUM_STATIONS'(1) << i;
            end
        end
    end

    assign instr_ready     = !commit.full && (|empty_vec);
    assign accept          = instr_valid && instr_ready;
    assign commit.alloc    = accept;
    assign commit.alloc_rd = instr.i.rd;

    for (genvar i = 0; i < NUM_STATIONS; i++) begin : g_stn
        assign empty_vec[i]          = stations[i].res_empty;
        assign stations[i].load_word = accept & load_sel[i];
        assign stations[i].res_in    = res_word;

        // station idle when handed an instruction and holding it right after
        assert property (@(posedge clk) disable iff (rst)
            stations[i].load_word |-> stations[i].res_empty ##1 !stations[i].res_empty)
            else $error("station %0d loaded while occupied or did not take the word", i);
    end

    // commit first, a new rename of the same rd overrides the busy clear
    always_ff @(posedge clk) begin
        if (rst) begin
            reg_busy <= '0;
            for (int r = 0; r < 32; r++) begin
                regs[r] <= '0;
            end
        end else begin
            if (commit.valid) begin
                if (commit.rd != 5'd0) begin
                    regs[commit.rd] <= commit.data;
                end
                // only the latest writer releases the register
                if (reg_tag[commit.rd] == commit.tag) begin
                    reg_busy[commit.rd] <= 1'b0;
                end
            end
            if (accept && instr.r.rd != 5'd0) begin
                reg_busy[instr.r.rd] <= 1'b1;
            end
        end
    end

    // x0 tag written too, never looked at since x0 never goes busy
    always_ff @(posedge clk) begin
        if (accept) begin
            reg_tag[instr.r.rd] <= commit.tail_tag;
        end
    end

endmodule

`default_nettype wire

// ==== hw/reorder_buffer.sv ====
`timescale 1ns/1ns
`default_nettype none

module reorder_buffer (
    input  logic                         clk,
    input  logic                         rst,
    commit_if.rob                        commit,
    result_bus_if.rob                    results,
    output logic                         commit_valid,
    output logic [4:0]                   commit_rd,
    output logic [rv32i_types::XLEN-1:0] commit_data
);

    localparam int DEPTH = tomasulo_types::ROB_DEPTH;

    // per entry payload
    logic [4:0]                   rd_q   [DEPTH];
    logic [rv32i_types::XLEN-1:0] data_q [DEPTH];

    // per entry control
    logic [DEPTH-1:0] alloc_q;
    logic [DEPTH-1:0] calc_q;

    tomasulo_types::tag_t   head;
    tomasulo_types::tag_t   tail;
    tomasulo_types::tag_t   commit_tag;
    logic [$clog2(DEPTH+1)-1:0] count;
    logic                   do_commit;

    // oldest entry leaves once its result is in
    assign do_commit = alloc_q[head] & calc_q[head];

    assign commit.tail_tag = tail;
    assign commit.full     = count == DEPTH;
    assign commit.valid    = commit_valid;
    assign commit.rd       = commit_rd;
    assign commit.tag      = commit_tag;
    assign commit.data     = commit_data;

    assign results.calculated = calc_q;
    assign results.result     = data_q;

    // calculated cleared only on reallocation, so a freed tag stays readable
    always_ff @(posedge clk) begin
        if (rst) begin
            head         <= '0;
            tail         <= '0;
            count        <= '0;
            alloc_q      <= '0;
            calc_q       <= '0;
            commit_valid <= 1'b0;
        end else begin
            commit_valid <= do_commit;
            if (commit.alloc) begin
                alloc_q[tail] <= 1'b1;
                calc_q[tail]  <= 1'b0;
                tail          <= tail + 1'b1;
            end
            if (results.wr_en) begin
                calc_q[results.wr_tag] <= 1'b1;
            end
            if (do_commit) begin
                alloc_q[head] <= 1'b0;
                head          <= head + 1'b1;
            end
            count <= count + commit.alloc - do_commit;
        end
    end

    always_ff @(posedge clk) begin
        if (commit.alloc) begin
            rd_q[tail] <= commit.alloc_rd;
        end
        if (results.wr_en) begin
            data_q[results.wr_tag] <= results.wr_data;
        end
        if (do_commit) begin
            commit_rd   <= rd_q[head];
            commit_data <= data_q[head];
            commit_tag  <= head;
        end
    end

    // dispatch must respect full
    assert property (@(posedge clk) disable iff (rst)
        commit.alloc |-> !commit.full)
        else $error("tag allocated while rob full");

    // alu only writes tags that are in flight
    assert property (@(posedge clk) disable iff (rst)
        results.wr_en |-> alloc_q[results.wr_tag])
        else $error("result written to free tag %0d", results.wr_tag);

endmodule

`default_nettype wire

// ==== hw/alu_unit.sv ====
`timescale 1ns/1ns
`default_nettype none

module alu_unit #(
    parameter int NUM_STATIONS = 3
) (
    input  logic [NUM_STATIONS-1:0]   start_exe,
    input  tomasulo_types::alu_word_t alu_data [NUM_STATIONS],
    output logic [NUM_STATIONS-1:0]   grant,
    result_bus_if.writer              wr
);

    tomasulo_types::alu_word_t    sel;
    logic [rv32i_types::XLEN-1:0] a;
    logic [rv32i_types::XLEN-1:0] b;
    logic [rv32i_types::XLEN-1:0] y;

    // fixed priority, station 0 highest
    always_comb begin
        grant = '0;
        sel   = alu_data[0];
        for (int i = NUM_STATIONS - 1; i >= 0; i--) begin
            if (start_exe[i]) begin
                grant = NUM_STATIONS'(1) << i;
                sel   = alu_data[i];
            end
        end
    end

    assign a = sel.src1_data;
    assign b = sel.src2_data;

    // shifts use the low five bits only
    always_comb begin
        case (sel.op)
            rv32i_types::ALU_ADD:  y = a + b;
            rv32i_types::ALU_SUB:  y = a - b;
            rv32i_types::ALU_SLL:  y = a << b[4:0];
            rv32i_types::ALU_SLT:  y = {31'd0, $signed(a) < $signed(b)};
            rv32i_types::ALU_SLTU: y = {31'd0, a < b};
            rv32i_types::ALU_XOR:  y = a ^ b;
            rv32i_types::ALU_SRL:  y = a >> b[4:0];
            rv32i_types::ALU_SRA:  y = $signed(a) >>> b[4:0];
            rv32i_types::ALU_OR:   y = a | b;
            default:               y = a & b;
        endcase
    end

    // result lands in the rob on the grant edge
    assign wr.wr_en   = |start_exe;
    assign wr.wr_tag  = sel.tag;
    assign wr.wr_data = y;

    // one grant, and always one when anybody asks
    always_comb begin
        assert final ($onehot0(grant) && ((|grant) == (|start_exe)))
            else $error("alu grant vector malformed: %b", grant);
    end

endmodule

`default_nettype wire

// ==== hw/reservation_station.sv ====
`timescale 1ns/1ns
`default_nettype none

module reservation_station (
    input  logic                      clk,
    input  logic                      rst,
    dispatch_if.station               disp,
    result_bus_if.reader              results,
    output logic                      start_exe,
    output tomasulo_types::alu_word_t alu_data,
    input  logic                      grant
);

    // CHECK is the first cycle after a load, PEEK every later wait cycle
    typedef enum logic [1:0] {
        EMPTY,
        CHECK,
        PEEK
    } state_e;

    state_e                    state;
    state_e                    next_state;
    tomasulo_types::res_word_t word;
    logic                      src1_ready;
    logic                      src2_ready;

    assign disp.res_empty = state == EMPTY;

    // a source is ready if captured or its tag finished
    assign src1_ready = word.src1.valid | results.calculated[word.src1.tag];
    assign src2_ready = word.src2.valid | results.calculated[word.src2.tag];
    assign start_exe  = (state != EMPTY) && src1_ready && src2_ready;

    // forward from the rob in the same cycle the tag shows up
    always_comb begin
        alu_data.op  = word.op;
        alu_data.tag = word.rd_tag;
        if (word.src1.valid) begin
            alu_data.src1_data = word.src1.data;
        end else begin
            alu_data.src1_data = results.result[word.src1.tag];
        end
        if (word.src2.valid) begin
            alu_data.src2_data = word.src2.data;
        end else begin
            alu_data.src2_data = results.result[word.src2.tag];
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            EMPTY: begin
                if (disp.load_word) begin
                    next_state = CHECK;
                end
            end
            CHECK, PEEK: begin
                // leave only once the alu took us
                if (start_exe && grant) begin
                    next_state = EMPTY;
                end else begin
                    next_state = PEEK;
                end
            end
            default: next_state = EMPTY;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= EMPTY;
        end else begin
            state <= next_state;
        end
    end

    // capture on load, then latch sources as their tags complete
    always_ff @(posedge clk) begin
        if (state == EMPTY) begin
            if (disp.load_word) begin
                word <= disp.res_in;
            end
        end else begin
            if (src1_ready) begin
                word.src1.valid <= 1'b1;
                word.src1.data  <= alu_data.src1_data;
            end
            if (src2_ready) begin
                word.src2.valid <= 1'b1;
                word.src2.data  <= alu_data.src2_data;
            end
        end
    end

    // an empty station never requests
    assert property (@(posedge clk) disable iff (rst)
        state == EMPTY |-> !start_exe)
        else $error("request from empty station");

    // request held with same operands until granted
    assert property (@(posedge clk) disable iff (rst)
        start_exe && !grant |=> start_exe && $stable(alu_data))
        else $error("station dropped or changed request before grant");

endmodule

`default_nettype wire

// ==== hw/tomasulo_ifs.sv ====
`timescale 1ns/1ns
`default_nettype none

// dispatch to one reservation station
interface dispatch_if;
    logic                      load_word;
    tomasulo_types::res_word_t res_in;
    logic                      res_empty;

    modport producer (output load_word, output res_in, input res_empty);
    modport station (input load_word, input res_in, output res_empty);
endinterface

// rob result store, read by everyone, written by the alu
interface result_bus_if;
    logic [tomasulo_types::ROB_DEPTH-1:0] calculated;
    logic [rv32i_types::XLEN-1:0]         result [tomasulo_types::ROB_DEPTH];
    logic                                 wr_en;
    tomasulo_types::tag_t                 wr_tag;
    logic [rv32i_types::XLEN-1:0]         wr_data;

    modport reader (input calculated, input result);
    modport writer (output wr_en, output wr_tag, output wr_data);
    modport rob (output calculated, output result, input wr_en, input wr_tag, input wr_data);
endinterface

// tag allocation and commit between rob and dispatch
interface commit_if;
    logic                         valid;
    logic [4:0]                   rd;
    tomasulo_types::tag_t         tag;
    logic [rv32i_types::XLEN-1:0] data;
    logic                         alloc;
    logic [4:0]                   alloc_rd;
    tomasulo_types::tag_t         tail_tag;
    logic                         full;

    modport dispatch (
        input  valid, input rd, input tag, input data,
        output alloc, output alloc_rd,
        input  tail_tag, input full
    );
    modport rob (
        output valid, output rd, output tag, output data,
        input  alloc, input alloc_rd,
        output tail_tag, output full
    );
endinterface

`default_nettype wire

// ==== hw/tomasulo_types.sv ====
`default_nettype none

package tomasulo_types;

    // reorder buffer entries, one per tag
    localparam int ROB_DEPTH = 8;
    localparam int TAG_W     = $clog2(ROB_DEPTH);

    typedef logic [TAG_W-1:0] tag_t;

    // one source operand of a waiting instruction
    // data only meaningful once valid is set
    typedef struct packed {
        tag_t                         tag;
        logic [rv32i_types::XLEN-1:0] data;
        logic                         valid;
    } src_t;

    // reservation station contents
    typedef struct packed {
        rv32i_types::alu_op_e op;
        src_t                 src1;
        src_t                 src2;
        tag_t                 rd_tag;
    } res_word_t;

    // request from a station to the alu
    typedef struct packed {
        rv32i_types::alu_op_e         op;
        logic [rv32i_types::XLEN-1:0] src1_data;
        logic [rv32i_types::XLEN-1:0] src2_data;
        tag_t                         tag;
    } alu_word_t;

endpackage

`default_nettype wire

// ==== hw/rv32i_types.sv ====
`default_nettype none

package rv32i_types;

    // data word width
    localparam int XLEN = 32;

    // major opcodes the core accepts
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011
    } opcode_e;

    // funct3 codes, shared by OP and OP-IMM
    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101;
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    // internal alu operation
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_e;

    // register-register layout
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    // register-immediate layout
    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    // same instruction word, two views
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
    } instr_u;

endpackage

`default_nettype wire
